//--- design/apbRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module apbRegs (
    input  wire logic             clk,
    input  wire logic             resetN,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire gamePkg::apbAddrT paddr,
    input  wire gamePkg::apbDataT pwdata,
    output gamePkg::apbDataT      prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  wire logic             startOfFrame,
    input  wire gamePkg::pixelT   topLeftX,
    input  wire gamePkg::pixelT   topLeftY,
    input  wire gamePkg::speedT   speedX,
    input  wire gamePkg::speedT   speedY,
    input  wire logic             monsterIsHit,
    output logic                  run,
    output logic                  missileActive,
    output gamePkg::pixelT        missileX,
    output gamePkg::pixelT        missileY,
    output logic                  speedLoad,
    output gamePkg::speedT        speedInX,
    output gamePkg::speedT        speedInY
);

    logic access;     // access phase of any transfer
    logic knownAddr;
    logic writeEn;
    gamePkg::frameCountT frameCount;

    assign access = psel && penable;

    always_comb begin
        case (paddr)
            `REG_CTRL, `REG_SPEED, `REG_MISSILE, `REG_POS, `REG_FRAMES: knownAddr = 1'b1;
            default: knownAddr = 1'b0;
        endcase
    end

    assign pready  = 1'b1; // every access completes in its first access phase
    assign pslverr = access && !knownAddr;
    assign writeEn = access && pwrite && knownAddr; // writes to holes are dropped

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            run           <= 1'b0;
            missileActive <= 1'b0;
            missileX      <= '0;
            missileY      <= '0;
            speedLoad     <= 1'b0;
        end else begin
            speedLoad <= 1'b0;
            if (writeEn) begin
                case (paddr)
                    `REG_CTRL: begin
                        run           <= pwdata[0];
                        missileActive <= pwdata[1];
                    end
                    `REG_SPEED: speedLoad <= 1'b1; // monster picks it up next clock
                    `REG_MISSILE: begin
                        missileX <= pwdata[10:0];
                        missileY <= pwdata[26:16];
                    end
                    default: ; // POS and FRAMES ignore writes
                endcase
            end
        end
    end

    // velocity word that monsterMove takes over while speedLoad is high
    always_ff @(posedge clk) begin
        if (writeEn && (paddr == `REG_SPEED)) begin
            speedInX <= pwdata[15:0];
            speedInY <= pwdata[31:16];
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            frameCount <= '0;
        end else if (startOfFrame) begin
            frameCount <= frameCount + 16'd1; // wraps after 65535 frames
        end
    end

    // read mux where unused addresses read as zero
    always_comb begin
        case (paddr)
            `REG_CTRL:    prdata = {30'b0, missileActive, run};
            `REG_SPEED:   prdata = {speedY, speedX};
            `REG_MISSILE: prdata = {5'b0, missileY, 5'b0, missileX};
            `REG_POS:     prdata = {monsterIsHit, 4'b0, topLeftY, 5'b0, topLeftX};
            `REG_FRAMES:  prdata = {16'b0, frameCount};
            default:      prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/collisionDetect.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module collisionDetect (
    input  wire logic              clk,
    input  wire logic              resetN,
    input  wire gamePkg::pixelT    topLeftX,
    input  wire gamePkg::pixelT    topLeftY,
    input  wire logic              missileActive,
    input  wire gamePkg::pixelT    missileX,
    input  wire gamePkg::pixelT    missileY,
    output gamePkg::edgeCodeT      hitEdgeCode,
    output logic                   borderCollision,
    output logic                   missileCollision
);

    // coordinates widened to int so that adding a size cannot wrap
    int monLeft;
    int monTop;
    int misLeft;
    int misTop;
    logic overlapX;
    logic overlapY;
    logic overlap;

    always_comb begin
        monLeft = int'(topLeftX);
        monTop  = int'(topLeftY);
        misLeft = int'(missileX);
        misTop  = int'(missileY);
    end

    // an edge counts as hit once the rectangle touches it or has gone past it
    always_comb begin
        hitEdgeCode[3] = (monLeft <= 0);                         // left border
        hitEdgeCode[2] = (monTop <= 0);                          // top border
        hitEdgeCode[1] = (monLeft + `MONSTER_W >= `SCREEN_W);    // right border
        hitEdgeCode[0] = (monTop + `MONSTER_H >= `SCREEN_H);     // bottom border
    end

    assign borderCollision = |hitEdgeCode;

    // both rectangles are half open, so sharing only an edge line is no overlap
    assign overlapX = (misLeft < monLeft + `MONSTER_W) && (monLeft < misLeft + `MISSILE_W);
    assign overlapY = (misTop < monTop + `MONSTER_H) && (monTop < misTop + `MISSILE_H);
    assign overlap  = overlapX && overlapY;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            missileCollision <= 1'b0;
        end else begin
            // an inactive missile is not on screen and cannot hit anything
            missileCollision <= missileActive && overlap;
        end
    end

endmodule

`default_nettype wire

//--- design/frameTimer.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module frameTimer (
    input  wire logic clk,
    input  wire logic resetN,
    input  wire logic run,
    output logic      startOfFrame // one clock wide once per frame period while running
);

    localparam int CntW = $clog2(`FRAME_CYCLES);

    gamePkg::timerStateT state;
    logic [CntW-1:0] cycleCnt; // clocks seen in the current frame

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state        <= gamePkg::IDLE;
            cycleCnt     <= '0;
            startOfFrame <= 1'b0;
        end else begin
            startOfFrame <= 1'b0; // pulse lasts a single clock
            case (state)
                gamePkg::IDLE: begin
                    cycleCnt <= '0;
                    if (run) begin
                        state    <= gamePkg::COUNT;
                        cycleCnt <= CntW'(1); // the clock that saw run counts as the first one
                    end
                end
                gamePkg::COUNT: begin
                    if (!run) begin
                        state    <= gamePkg::IDLE; // stopping drops the partial frame
                        cycleCnt <= '0;
                    end else if (cycleCnt == CntW'(`FRAME_CYCLES - 1)) begin
                        startOfFrame <= 1'b1;
                        cycleCnt     <= '0; // reload for the next frame
                    end else begin
                        cycleCnt <= cycleCnt + CntW'(1);
                    end
                end
                default: state <= gamePkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/gamePkg.sv
`default_nettype none

package gamePkg;

    typedef logic signed [10:0] pixelT; // screen coordinate that goes negative when partly off screen

    typedef logic signed [17:0] fixPosT; // position in 1/64 pixel

    typedef logic signed [15:0] speedT; // velocity in 1/64 pixel per frame

    // touched borders with bit 3 left, 2 top, 1 right and 0 bottom
    typedef logic [3:0] edgeCodeT;

    typedef logic [7:0] apbAddrT;
    typedef logic [31:0] apbDataT;

    typedef logic [15:0] frameCountT; // frame ticks since reset

    typedef enum logic {IDLE, COUNT} timerStateT;

endpackage

`default_nettype wire

//--- design/monsterMove.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module monsterMove (
    input  wire logic              clk,
    input  wire logic              resetN,
    input  wire logic              startOfFrame,     // one clock pulse per frame
    input  wire logic              missileCollision,
    input  wire logic              borderCollision,
    input  wire gamePkg::edgeCodeT hitEdgeCode,
    input  wire logic              rndBit,
    input  wire logic              speedLoad,        // host wrote a new velocity
    input  wire gamePkg::speedT    speedInX,
    input  wire gamePkg::speedT    speedInY,
    output logic                   monsterIsHit,
    output gamePkg::pixelT         topLeftX,
    output gamePkg::pixelT         topLeftY,
    output gamePkg::speedT         speedX,
    output gamePkg::speedT         speedY
);

    gamePkg::fixPosT posX; // top left corner in 1/64 pixel
    gamePkg::fixPosT posY;
    logic flipX;
    logic flipY;
    gamePkg::speedT bounceX;
    gamePkg::speedT bounceY;

    // a bounce only counts while moving into the border, so a monster
    // already heading back inside is left alone
    always_comb begin
        flipY = borderCollision &&
                ((hitEdgeCode[2] && (speedY < 0)) ||    // ceiling while moving up
                 (hitEdgeCode[0] && (speedY > 0)));     // floor while moving down
        flipX = borderCollision &&
                ((hitEdgeCode[3] && (speedX < 0)) ||    // left wall while moving left
                 (hitEdgeCode[1] && (speedX > 0)));     // right wall while moving right
        // the random bit also turns the other axis around on a bounce
        bounceX = (flipX ^ (flipY && rndBit)) ? -speedX : speedX;
        bounceY = (flipY ^ (flipX && rndBit)) ? -speedY : speedY;
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            monsterIsHit <= 1'b0;
            speedX       <= '0;
            speedY       <= '0;
            posX         <= gamePkg::fixPosT'(`INIT_X << `FRAC_BITS);
            posY         <= gamePkg::fixPosT'(`INIT_Y << `FRAC_BITS);
        end else begin
            if (monsterIsHit || missileCollision) begin
                monsterIsHit <= 1'b1; // sticky until the next reset
                speedX       <= '0;
                speedY       <= '0;
            end else if (speedLoad) begin
                speedX <= speedInX;
                speedY <= speedInY;
            end else begin
                speedX <= bounceX;
                speedY <= bounceY;
            end

            if (startOfFrame) begin
                posX <= posX + gamePkg::fixPosT'(speedX); // one velocity step per frame
                posY <= posY + gamePkg::fixPosT'(speedY);
            end
        end
    end

    // arithmetic shift keeps the sign for positions off the left or top edge
    assign topLeftX = gamePkg::pixelT'(posX >>> `FRAC_BITS);
    assign topLeftY = gamePkg::pixelT'(posY >>> `FRAC_BITS);

endmodule

`default_nettype wire

//--- design/monsterSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module monsterSubsystem (
    input  wire logic             clk,
    input  wire logic             resetN,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire gamePkg::apbAddrT paddr,
    input  wire gamePkg::apbDataT pwdata,
    output gamePkg::apbDataT      prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // host control toward the game blocks
    logic run;
    logic missileActive;
    gamePkg::pixelT missileX;
    gamePkg::pixelT missileY;
    logic speedLoad;
    gamePkg::speedT speedInX;
    gamePkg::speedT speedInY;

    // game state between the blocks
    logic startOfFrame;
    logic rndBit;
    logic monsterIsHit;
    gamePkg::pixelT topLeftX;
    gamePkg::pixelT topLeftY;
    gamePkg::speedT speedX;
    gamePkg::speedT speedY;
    gamePkg::edgeCodeT hitEdgeCode;
    logic borderCollision;
    logic missileCollision;

    frameTimer frameTimer_inst (
        .clk, .resetN, .run, .startOfFrame
    );

    randomBit randomBit_inst (
        .clk, .resetN, .rndBit
    );

    collisionDetect collisionDetect_inst (
        .clk, .resetN, .topLeftX, .topLeftY, .missileActive, .missileX, .missileY,
        .hitEdgeCode, .borderCollision, .missileCollision
    );

    monsterMove monsterMove_inst (
        .clk, .resetN, .startOfFrame, .missileCollision, .borderCollision, .hitEdgeCode,
        .rndBit, .speedLoad, .speedInX, .speedInY,
        .monsterIsHit, .topLeftX, .topLeftY, .speedX, .speedY
    );

    apbRegs apbRegs_inst (
        .clk, .resetN, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .startOfFrame, .topLeftX, .topLeftY, .speedX, .speedY, .monsterIsHit,
        .run, .missileActive, .missileX, .missileY, .speedLoad, .speedInX, .speedInY
    );

endmodule

`default_nettype wire

//--- design/randomBit.sv
`timescale 1ns/1ps
`default_nettype none

module randomBit (
    input  wire logic clk,
    input  wire logic resetN,
    output logic      rndBit
);

    localparam logic [15:0] Seed = 16'hACE1; // any nonzero seed keeps the sequence alive

    logic [15:0] lfsr;
    logic        feedback;

    // taps 16, 14, 13 and 11 counted from the output end give a maximal length sequence
    assign feedback = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lfsr <= Seed;
        end else begin
            lfsr <= {feedback, lfsr[15:1]}; // shift toward bit 0 every clock
        end
    end

    assign rndBit = lfsr[0];

endmodule

`default_nettype wire

//--- include/game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// visible screen in pixels
`define SCREEN_W 640
`define SCREEN_H 480

// monster sprite rectangle in pixels
`define MONSTER_W 32
`define MONSTER_H 32

// start position of the top left corner after reset
`define INIT_X 300
`define INIT_Y 200

`define FRAC_BITS 6 // position carries 1/64 pixel below the integer part

`define FRAME_CYCLES 50 // clocks between frame ticks, far shorter than a real frame

// missile rectangle in pixels
`define MISSILE_W 4
`define MISSILE_H 8

// register byte addresses on the APB side
`define REG_CTRL    8'h00
`define REG_SPEED   8'h04
`define REG_MISSILE 8'h08
`define REG_POS     8'h0C
`define REG_FRAMES  8'h10

`endif

//--- run.sh
#!/bin/sh
# build and run the monster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module monsterTb -o monsterSim

./obj_dir/monsterSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tb.f
+incdir+include
design/gamePkg.sv
design/frameTimer.sv
design/randomBit.sv
design/collisionDetect.sv
design/monsterMove.sv
design/apbRegs.sv
design/monsterSubsystem.sv
tests/clockGen.sv
tests/monsterSubsystem_chk.sv
tests/monsterTb.sv

//--- tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    input  wire logic resetReq, // testbench asks for a reset between table rows
    output logic      clk,
    output logic      resetN
);

    logic startReset; // power-on reset of two clocks

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        startReset = 1'b1;
        repeat (2) @(posedge clk);
        #2 startReset = 1'b0;
    end

    assign resetN = !(startReset || resetReq);

endmodule

`default_nettype wire

//--- tests/monsterSubsystem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module monsterSubsystem_chk (
    input wire logic           clk,
    input wire logic           resetN,
    input wire logic           psel,
    input wire logic           penable,
    input wire logic           pready,
    input wire logic           startOfFrame,
    input wire logic           monsterIsHit,
    input wire gamePkg::speedT speedX,
    input wire gamePkg::speedT speedY
);

    // a frame tick is a single clock wide
    frameTickSingle: assert property (@(posedge clk) disable iff (!resetN)
        startOfFrame |=> !startOfFrame)
        else $error("startOfFrame high on two consecutive clocks");

    hitIsSticky: assert property (@(posedge clk) disable iff (!resetN)
        monsterIsHit |=> monsterIsHit)
        else $error("monsterIsHit fell without a reset");

    // the slave never inserts wait states
    noWaitStates: assert property (@(posedge clk) disable iff (!resetN)
        (psel && penable) |-> pready)
        else $error("pready low in an access phase");

    hitStopsMonster: assert property (@(posedge clk) disable iff (!resetN)
        monsterIsHit |=> (speedX == '0 && speedY == '0))
        else $error("velocity not zero after the monster was hit");

endmodule

bind monsterSubsystem monsterSubsystem_chk monsterSubsystem_chk_inst (.*);

`default_nettype wire

//--- tests/monsterTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module monsterTb;

    localparam int NumRows   = 11;
    localparam int FixedRows = 5;
    localparam int WaitLimit = 20; // clocks allowed for pready

    logic clk;
    logic resetN;
    logic resetReq;
    logic psel;
    logic penable;
    logic pwrite;
    gamePkg::apbAddrT paddr;
    gamePkg::apbDataT pwdata;
    gamePkg::apbDataT prdata;
    logic pready;
    logic pslverr;

    int valueErrors = 0;
    int timeoutErrors = 0;
    logic [31:0] rngState = 32'd10447;

    // stimulus table with one entry per row in each array
    gamePkg::speedT rowSpeedX[NumRows];
    gamePkg::speedT rowSpeedY[NumRows];
    gamePkg::pixelT rowMisX[NumRows];
    gamePkg::pixelT rowMisY[NumRows];
    logic rowMisActive[NumRows];
    int rowFrames[NumRows];
    logic rowExpHit[NumRows];
    logic rowBounce[NumRows]; // row runs into a side wall

    clockGen clockGen_inst (.resetReq, .clk, .resetN);

    monsterSubsystem monsterSubsystem_inst (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int absInt(input int v);
        return (v < 0) ? -v : v;
    endfunction

    task automatic abortRun(input string why);
        timeoutErrors++;
        $display("%s at %0t", why, $time);
        $display("errors: %0d wrong values, %0d timeouts", valueErrors, timeoutErrors);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic checkPixel(input string what, input gamePkg::pixelT got,
                              input gamePkg::pixelT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail %0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkSpeed(input string what, input gamePkg::speedT got,
                              input gamePkg::speedT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail %0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail %0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkData(input string what, input gamePkg::apbDataT got,
                             input gamePkg::apbDataT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    // setup phase, then access phase that waits for pready
    task automatic apbAccess(input logic write, input gamePkg::apbAddrT addr,
                             input gamePkg::apbDataT wdata, output gamePkg::apbDataT rdata,
                             output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #2 penable = 1'b1;
        while (!pready) begin
            if (waited >= WaitLimit) abortRun("pready never came on the APB access");
            @(posedge clk);
            #2;
            waited++;
        end
        #6; // sample the read data mid cycle, well away from either edge
        rdata = prdata;
        err = pslverr;
        @(posedge clk); // write takes effect on this edge
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbWrite(input gamePkg::apbAddrT addr, input gamePkg::apbDataT data);
        gamePkg::apbDataT unused;
        logic err;
        apbAccess(1'b1, addr, data, unused, err);
        checkFlag($sformatf("pslverr on write to %h", addr), err, 1'b0);
    endtask

    task automatic apbRead(input gamePkg::apbAddrT addr, output gamePkg::apbDataT data);
        logic err;
        apbAccess(1'b0, addr, '0, data, err);
        checkFlag($sformatf("pslverr on read of %h", addr), err, 1'b0);
    endtask

    // poll FRAMES until the count reaches target
    task automatic waitFrames(input int target);
        gamePkg::apbDataT data;
        int polls;
        polls = 0;
        apbRead(`REG_FRAMES, data);
        while (int'(data[15:0]) < target) begin
            if (polls >= target * `FRAME_CYCLES / 2 + 100) abortRun("frame count never reached");
            apbRead(`REG_FRAMES, data);
            polls++;
        end
    endtask

    task automatic pulseReset();
        @(posedge clk);
        #2 resetReq = 1'b1;
        repeat (2) @(posedge clk);
        #2 resetReq = 1'b0;
    endtask

    task automatic runRow(input int i);
        gamePkg::apbDataT data;
        gamePkg::apbDataT ctrl;
        int frames;
        int expX;
        int expY;
        int stepX;
        gamePkg::pixelT posX;
        gamePkg::speedT sx;
        gamePkg::speedT sy;
        pulseReset();
        ctrl = {30'b0, rowMisActive[i], 1'b1};
        apbWrite(`REG_SPEED, {rowSpeedY[i], rowSpeedX[i]});
        apbWrite(`REG_MISSILE, {5'b0, rowMisY[i], 5'b0, rowMisX[i]});
        apbWrite(`REG_CTRL, ctrl);
        waitFrames(rowFrames[i]);
        apbWrite(`REG_CTRL, ctrl & ~32'd1); // stopping freezes the position
        apbRead(`REG_FRAMES, data);
        frames = int'(data[15:0]);
        apbRead(`REG_POS, data);
        posX = data[10:0];
        checkFlag($sformatf("row %0d hit flag", i), data[31], rowExpHit[i]);
        if (rowExpHit[i]) begin
            // hit lands before the first frame tick, so the monster never moved
            checkPixel($sformatf("row %0d hit x", i), posX, gamePkg::pixelT'(`INIT_X));
            checkPixel($sformatf("row %0d hit y", i), data[26:16], gamePkg::pixelT'(`INIT_Y));
            apbRead(`REG_SPEED, data);
            checkData($sformatf("row %0d hit speed", i), data, '0);
            apbWrite(`REG_CTRL, ctrl);
            waitFrames(frames + 2);
            apbWrite(`REG_CTRL, ctrl & ~32'd1);
            apbRead(`REG_POS, data);
            checkPixel($sformatf("row %0d x after hit", i), data[10:0],
                       gamePkg::pixelT'(`INIT_X));
            checkPixel($sformatf("row %0d y after hit", i), data[26:16],
                       gamePkg::pixelT'(`INIT_Y));
            apbWrite(`REG_SPEED, 32'h0005_0005);
            apbRead(`REG_SPEED, data);
            checkData($sformatf("row %0d speed write after hit", i), data, '0);
        end else if (rowBounce[i]) begin
            apbRead(`REG_SPEED, data);
            sx = data[15:0];
            sy = data[31:16];
            checkSpeed($sformatf("row %0d |speed x|", i), gamePkg::speedT'(absInt(int'(sx))),
                       gamePkg::speedT'(absInt(int'(rowSpeedX[i]))));
            checkSpeed($sformatf("row %0d |speed y|", i), gamePkg::speedT'(absInt(int'(sy))),
                       gamePkg::speedT'(absInt(int'(rowSpeedY[i]))));
            // one X step rounded up to whole pixels
            stepX = (absInt(int'(rowSpeedX[i])) + (1 << `FRAC_BITS) - 1) >>> `FRAC_BITS;
            // may overshoot a border by at most one step before turning
            checkFlag($sformatf("row %0d x %0d near screen", i, posX),
                      (int'(posX) >= -stepX) &&
                      (int'(posX) <= `SCREEN_W - `MONSTER_W + stepX), 1'b1);
        end else begin
            expX = ((`INIT_X << `FRAC_BITS) + frames * int'(rowSpeedX[i])) >>> `FRAC_BITS;
            expY = ((`INIT_Y << `FRAC_BITS) + frames * int'(rowSpeedY[i])) >>> `FRAC_BITS;
            checkPixel($sformatf("row %0d x", i), posX, gamePkg::pixelT'(expX));
            checkPixel($sformatf("row %0d y", i), data[26:16], gamePkg::pixelT'(expY));
            apbRead(`REG_SPEED, data);
            checkSpeed($sformatf("row %0d speed x", i), data[15:0], rowSpeedX[i]);
            checkSpeed($sformatf("row %0d speed y", i), data[31:16], rowSpeedY[i]);
        end
    endtask

    task automatic checkRegisters();
        gamePkg::apbDataT data;
        logic err;
        pulseReset();
        apbWrite(`REG_CTRL, 32'h0000_0002); // missile on while the monster stays parked
        apbRead(`REG_CTRL, data);
        checkData("CTRL readback", data, 32'h0000_0002);
        apbWrite(`REG_MISSILE, 32'h0123_0456);
        apbRead(`REG_MISSILE, data);
        checkData("MISSILE readback", data, 32'h0123_0456);
        apbAccess(1'b1, 8'h20, 32'hFFFF_FFFF, data, err);
        checkFlag("pslverr on write to unused address", err, 1'b1);
        apbAccess(1'b0, 8'h20, '0, data, err);
        checkFlag("pslverr on read of unused address", err, 1'b1);
        checkData("unused address read", data, '0);
    endtask

    initial begin
        int waited;
        resetReq = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;

        // free flight, wall bounce, hit, inactive missile, disjoint missile
        rowSpeedX = '{100, 2000, 100, 100, 100, 0, 0, 0, 0, 0, 0};
        rowSpeedY = '{-50, 64, 100, 100, 100, 0, 0, 0, 0, 0, 0};
        rowMisX = '{0, 0, 310, 310, 50, 0, 0, 0, 0, 0, 0};
        rowMisY = '{0, 0, 210, 210, 50, 0, 0, 0, 0, 0, 0};
        rowMisActive = '{0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0};
        rowFrames = '{5, 20, 3, 3, 4, 0, 0, 0, 0, 0, 0};
        rowExpHit = '{0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0};
        rowBounce = '{0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        // random rows stay small and far from the missile corner, so they fly free
        for (int i = FixedRows; i < NumRows; i++) begin
            rngState = xorshift(rngState);
            rowSpeedX[i] = gamePkg::speedT'(int'(rngState % 511) - 255);
            rngState = xorshift(rngState);
            rowSpeedY[i] = gamePkg::speedT'(int'(rngState % 511) - 255);
            rngState = xorshift(rngState);
            rowMisX[i] = gamePkg::pixelT'(rngState % 100);
            rowMisY[i] = gamePkg::pixelT'((rngState >> 8) % 100);
            rowMisActive[i] = rngState[20];
            rowFrames[i] = 1 + int'((rngState >> 24) % 8);
            rowExpHit[i] = 1'b0;
            rowBounce[i] = 1'b0;
        end

        waited = 0;
        while (resetN !== 1'b1) begin
            if (waited >= WaitLimit) abortRun("reset never released");
            @(posedge clk);
            waited++;
        end

        for (int i = 0; i < NumRows; i++) runRow(i);
        checkRegisters();

        $display("errors: %0d wrong values, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
